//--- design/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path and pc width
`define RV_XLEN 32
// register index width
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32
// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000
`define RV_INSN_W 32

`endif

//--- design/rv_isa_pkg.sv
`include "rv_params.svh"

package rv_isa_pkg;

  // major opcodes still supported
  typedef enum logic [6:0] {
    OPC_REG_REG = 7'b0110011,
    OPC_REG_IMM = 7'b0010011,
    OPC_LUI     = 7'b0110111,
    OPC_BRANCH  = 7'b1100011,
    OPC_JAL     = 7'b1101111,
    OPC_ENVIRON = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // lui passes the second operand straight through
    ALU_PASS,
    // jal link value
    ALU_PC_PLUS4
  } alu_op_e;

  // encoded as funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic use_imm;
    logic is_branch;
    logic is_jal;
    logic is_ecall;
    branch_cond_e branch_cond;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic reg_write;
    // already sign-extended for its format
    logic [`RV_XLEN-1:0] imm;
  } decoded_insn_t;

endpackage

//--- design/rv_pipe_pkg.sv
`include "rv_params.svh"

package rv_pipe_pkg;

  // what occupies writeback in a given cycle
  typedef enum logic [1:0] {
    CYCLE_INVALID      = 2'd0,
    CYCLE_RESET        = 2'd1,
    CYCLE_NO_STALL     = 2'd2,
    CYCLE_TAKEN_BRANCH = 2'd3
  } cycle_status_e;

  // fetch to decode
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_INSN_W-1:0] insn;
    cycle_status_e status;
  } fetch_stage_t;

  // decode to execute
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_INSN_W-1:0] insn;
    cycle_status_e status;
    rv_isa_pkg::decoded_insn_t dec;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
  } execute_stage_t;

  // execute to writeback
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_INSN_W-1:0] insn;
    cycle_status_e status;
    logic [`RV_XLEN-1:0] result;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic reg_write;
    logic is_ecall;
  } writeback_stage_t;

  typedef struct packed {
    logic taken;
    logic [`RV_XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic we;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0] data;
  } reg_write_t;

endpackage

//--- design/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`RV_REG_ADDR_W-1:0]  rs1_addr,
  input  logic [`RV_REG_ADDR_W-1:0]  rs2_addr,
  output logic [`RV_XLEN-1:0]        rs1_data,
  output logic [`RV_XLEN-1:0]        rs2_data,
  input  rv_pipe_pkg::reg_write_t    wr
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // a same-cycle write to the read register wins
  assign rs1_data = (rs1_addr == '0) ? '0 :
                    (wr.we && wr.rd == rs1_addr) ? wr.data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    (wr.we && wr.rd == rs2_addr) ? wr.data : regs[rs2_addr];

endmodule

//--- design/rv_fetch.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_fetch (
  input  logic                        clk,
  input  logic                        rst,
  output logic [`RV_XLEN-1:0]         imem_pc,
  input  logic [`RV_INSN_W-1:0]       imem_insn,
  input  rv_pipe_pkg::redirect_t      redirect,
  output rv_pipe_pkg::fetch_stage_t   fetch_out
);

  logic [`RV_XLEN-1:0] pc;

  assign imem_pc = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
      fetch_out <= '{pc: '0, insn: '0, status: rv_pipe_pkg::CYCLE_RESET};
    end else if (redirect.taken) begin
      // bubble replaces the wrong-path fetch
      pc <= redirect.target;
      fetch_out <= '{pc: '0, insn: '0, status: rv_pipe_pkg::CYCLE_TAKEN_BRANCH};
    end else begin
      pc <= pc + `RV_XLEN'd4;
      fetch_out <= '{pc: pc, insn: imem_insn, status: rv_pipe_pkg::CYCLE_NO_STALL};
    end
  end

endmodule

//--- design/rv_decode.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decode (
  input  logic                         clk,
  input  logic                         rst,
  input  rv_pipe_pkg::fetch_stage_t    fetch_in,
  input  rv_pipe_pkg::redirect_t       redirect,
  output logic [`RV_REG_ADDR_W-1:0]    rs1_addr,
  output logic [`RV_REG_ADDR_W-1:0]    rs2_addr,
  input  logic [`RV_XLEN-1:0]          rs1_data,
  input  logic [`RV_XLEN-1:0]          rs2_data,
  output rv_pipe_pkg::execute_stage_t  execute_out
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  rv_isa_pkg::decoded_insn_t dec;

  // funct3 mapping shared by reg-reg and reg-imm forms
  function automatic rv_isa_pkg::alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return rv_isa_pkg::ALU_ADD;
      3'b001:  return rv_isa_pkg::ALU_SLL;
      3'b010:  return rv_isa_pkg::ALU_SLT;
      3'b011:  return rv_isa_pkg::ALU_SLTU;
      3'b100:  return rv_isa_pkg::ALU_XOR;
      3'b101:  return rv_isa_pkg::ALU_SRL;
      3'b110:  return rv_isa_pkg::ALU_OR;
      default: return rv_isa_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = rv_isa_pkg::opcode_e'(fetch_in.insn[6:0]);
  assign funct3 = fetch_in.insn[14:12];
  assign funct7 = fetch_in.insn[31:25];
  assign rs1_addr = fetch_in.insn[19:15];
  assign rs2_addr = fetch_in.insn[24:20];

  assign imm_i = {{20{fetch_in.insn[31]}}, fetch_in.insn[31:20]};
  assign imm_b = {{19{fetch_in.insn[31]}}, fetch_in.insn[31], fetch_in.insn[7],
                  fetch_in.insn[30:25], fetch_in.insn[11:8], 1'b0};
  assign imm_u = {fetch_in.insn[31:12], 12'h000};
  assign imm_j = {{11{fetch_in.insn[31]}}, fetch_in.insn[31], fetch_in.insn[19:12],
                  fetch_in.insn[20], fetch_in.insn[30:21], 1'b0};

  always_comb begin
    // unknown encodings fall out as no-write no-ops
    dec = '0;
    dec.rd = fetch_in.insn[11:7];
    case (opcode)
      rv_isa_pkg::OPC_REG_REG: begin
        dec.reg_write = 1'b1;
        dec.alu_op = base_op(funct3);
        if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec.alu_op = rv_isa_pkg::ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          dec.alu_op = rv_isa_pkg::ALU_SRA;
        end else if (funct7 != 7'b0000000) begin
          dec.reg_write = 1'b0;
        end
      end
      rv_isa_pkg::OPC_REG_IMM: begin
        dec.reg_write = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm = imm_i;
        dec.alu_op = base_op(funct3);
        // shifts carry a funct7 in the upper immediate bits
        if (funct3 == 3'b101 && funct7 == 7'b0100000) begin
          dec.alu_op = rv_isa_pkg::ALU_SRA;
        end else if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0000000) begin
          dec.reg_write = 1'b0;
        end
      end
      rv_isa_pkg::OPC_LUI: begin
        dec.reg_write = 1'b1;
        dec.use_imm = 1'b1;
        dec.imm = imm_u;
        dec.alu_op = rv_isa_pkg::ALU_PASS;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        // funct3 010 and 011 are not branches
        dec.is_branch = (funct3[2:1] != 2'b01);
        dec.branch_cond = rv_isa_pkg::branch_cond_e'(funct3);
        dec.imm = imm_b;
      end
      rv_isa_pkg::OPC_JAL: begin
        dec.is_jal = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm = imm_j;
        dec.alu_op = rv_isa_pkg::ALU_PC_PLUS4;
      end
      rv_isa_pkg::OPC_ENVIRON: begin
        dec.is_ecall = (fetch_in.insn[31:7] == 25'd0);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_out <= '{pc: '0, insn: '0, status: rv_pipe_pkg::CYCLE_RESET, dec: '0,
                       rs1_data: '0, rs2_data: '0};
    end else if (redirect.taken) begin
      // squash the wrong-path slot
      execute_out <= '{pc: '0, insn: '0, status: rv_pipe_pkg::CYCLE_TAKEN_BRANCH, dec: '0,
                       rs1_data: '0, rs2_data: '0};
    end else begin
      execute_out <= '{pc: fetch_in.pc, insn: fetch_in.insn, status: fetch_in.status,
                       dec: dec, rs1_data: rs1_data, rs2_data: rs2_data};
    end
  end

endmodule

//--- design/rv_execute.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_execute (
  input  logic                          clk,
  input  logic                          rst,
  input  rv_pipe_pkg::execute_stage_t   execute_in,
  output rv_pipe_pkg::redirect_t        redirect,
  output rv_pipe_pkg::writeback_stage_t writeback_out
);

  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [4:0] shamt;
  logic [`RV_XLEN-1:0] alu_result;
  logic cond_true;
  logic taken;

  assign alu_a = execute_in.rs1_data;
  assign alu_b = execute_in.dec.use_imm ? execute_in.dec.imm : execute_in.rs2_data;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (execute_in.dec.alu_op)
      rv_isa_pkg::ALU_ADD:      alu_result = alu_a + alu_b;
      rv_isa_pkg::ALU_SUB:      alu_result = alu_a - alu_b;
      rv_isa_pkg::ALU_SLL:      alu_result = alu_a << shamt;
      rv_isa_pkg::ALU_SLT:      alu_result = {31'd0, $signed(alu_a) < $signed(alu_b)};
      rv_isa_pkg::ALU_SLTU:     alu_result = {31'd0, alu_a < alu_b};
      rv_isa_pkg::ALU_XOR:      alu_result = alu_a ^ alu_b;
      rv_isa_pkg::ALU_SRL:      alu_result = alu_a >> shamt;
      rv_isa_pkg::ALU_SRA:      alu_result = $signed(alu_a) >>> shamt;
      rv_isa_pkg::ALU_OR:       alu_result = alu_a | alu_b;
      rv_isa_pkg::ALU_AND:      alu_result = alu_a & alu_b;
      rv_isa_pkg::ALU_PASS:     alu_result = alu_b;
      rv_isa_pkg::ALU_PC_PLUS4: alu_result = execute_in.pc + `RV_XLEN'd4;
      default:                  alu_result = '0;
    endcase
  end

  // branch compare always uses both registers
  always_comb begin
    case (execute_in.dec.branch_cond)
      rv_isa_pkg::BR_EQ:  cond_true = (execute_in.rs1_data == execute_in.rs2_data);
      rv_isa_pkg::BR_NE:  cond_true = (execute_in.rs1_data != execute_in.rs2_data);
      rv_isa_pkg::BR_LT:  cond_true = ($signed(execute_in.rs1_data) <
                                       $signed(execute_in.rs2_data));
      rv_isa_pkg::BR_GE:  cond_true = ($signed(execute_in.rs1_data) >=
                                       $signed(execute_in.rs2_data));
      rv_isa_pkg::BR_LTU: cond_true = (execute_in.rs1_data < execute_in.rs2_data);
      rv_isa_pkg::BR_GEU: cond_true = (execute_in.rs1_data >= execute_in.rs2_data);
      default:            cond_true = 1'b0;
    endcase
  end

  // bubbles never redirect
  assign taken = (execute_in.status == rv_pipe_pkg::CYCLE_NO_STALL) &&
                 (execute_in.dec.is_jal || (execute_in.dec.is_branch && cond_true));

  assign redirect.taken = taken;
  assign redirect.target = execute_in.pc + execute_in.dec.imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      writeback_out <= '{pc: '0, insn: '0, status: rv_pipe_pkg::CYCLE_RESET, result: '0,
                         rd: '0, reg_write: 1'b0, is_ecall: 1'b0};
    end else begin
      writeback_out <= '{pc: execute_in.pc, insn: execute_in.insn,
                         status: execute_in.status, result: alu_result,
                         rd: execute_in.dec.rd, reg_write: execute_in.dec.reg_write,
                         is_ecall: execute_in.dec.is_ecall};
    end
  end

endmodule

//--- design/rv_writeback.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_writeback (
  input  logic                          clk,
  input  logic                          rst,
  input  rv_pipe_pkg::writeback_stage_t writeback_in,
  output rv_pipe_pkg::reg_write_t       reg_wr,
  output logic                          halt,
  output logic [`RV_XLEN-1:0]           trace_pc,
  output logic [`RV_INSN_W-1:0]         trace_insn,
  output rv_pipe_pkg::cycle_status_e    trace_status
);

  logic valid;

  assign valid = (writeback_in.status == rv_pipe_pkg::CYCLE_NO_STALL);

  // x0 writes dropped here as well as in the register file
  assign reg_wr.we = valid && writeback_in.reg_write && (writeback_in.rd != '0);
  assign reg_wr.rd = writeback_in.rd;
  assign reg_wr.data = writeback_in.result;

  // sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      halt <= 1'b0;
    end else if (valid && writeback_in.is_ecall) begin
      halt <= 1'b1;
    end
  end

  assign trace_pc = writeback_in.pc;
  assign trace_insn = writeback_in.insn;
  assign trace_status = writeback_in.status;

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core (
  input  logic                       clk,
  input  logic                       rst,
  output logic [`RV_XLEN-1:0]        imem_pc,
  input  logic [`RV_INSN_W-1:0]      imem_insn,
  output logic                       halt,
  output logic [`RV_XLEN-1:0]        trace_writeback_pc,
  output logic [`RV_INSN_W-1:0]      trace_writeback_insn,
  output rv_pipe_pkg::cycle_status_e trace_writeback_cycle_status,
  output rv_pipe_pkg::reg_write_t    trace_writeback_reg
);

  rv_pipe_pkg::fetch_stage_t fetch_stage;
  rv_pipe_pkg::execute_stage_t execute_stage;
  rv_pipe_pkg::writeback_stage_t writeback_stage;
  rv_pipe_pkg::redirect_t redirect;
  rv_pipe_pkg::reg_write_t reg_wr;
  logic [`RV_REG_ADDR_W-1:0] rs1_addr;
  logic [`RV_REG_ADDR_W-1:0] rs2_addr;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;

  rv_fetch fetch_i (
    .clk       (clk),
    .rst       (rst),
    .imem_pc   (imem_pc),
    .imem_insn (imem_insn),
    .redirect  (redirect),
    .fetch_out (fetch_stage)
  );

  rv_decode decode_i (
    .clk         (clk),
    .rst         (rst),
    .fetch_in    (fetch_stage),
    .redirect    (redirect),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .execute_out (execute_stage)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (reg_wr)
  );

  rv_execute execute_i (
    .clk           (clk),
    .rst           (rst),
    .execute_in    (execute_stage),
    .redirect      (redirect),
    .writeback_out (writeback_stage)
  );

  rv_writeback writeback_i (
    .clk          (clk),
    .rst          (rst),
    .writeback_in (writeback_stage),
    .reg_wr       (reg_wr),
    .halt         (halt),
    .trace_pc     (trace_writeback_pc),
    .trace_insn   (trace_writeback_insn),
    .trace_status (trace_writeback_cycle_status)
  );

  // the write request doubles as the trace
  assign trace_writeback_reg = reg_wr;

endmodule

//--- testbench/rv_clock_gen.sv
`timescale 1ns/1ps

module rv_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // released 1 ns after the 16th rising edge
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

//--- testbench/rv_core_assertions.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_assertions (
  input logic                       clk,
  input logic                       rst,
  input logic                       halt,
  input logic [`RV_XLEN-1:0]        trace_pc,
  input logic [`RV_INSN_W-1:0]      trace_insn,
  input rv_pipe_pkg::cycle_status_e trace_status,
  input rv_pipe_pkg::reg_write_t    trace_reg
);

  int fail_count = 0;
  logic [`RV_XLEN-1:0] shadow [0:`RV_NUM_REGS-1];
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rd;
  logic [`RV_XLEN-1:0] src1;
  logic [`RV_XLEN-1:0] src2;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] expected;
  logic [`RV_XLEN-1:0] jump_target;
  logic [`RV_XLEN-1:0] seq_next_pc;
  logic valid;
  logic writes_reg;
  logic cond_true;
  logic transfer;
  logic ecall;
  logic seq_valid;

  // rv32i integer semantics where alt selects sub and sra
  function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // register state as seen by the instruction now in writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        shadow[i] <= '0;
      end
    end else if (trace_reg.we && trace_reg.rd != '0) begin
      shadow[trace_reg.rd] <= trace_reg.data;
    end
  end

  always_comb begin
    opcode = trace_insn[6:0];
    funct3 = trace_insn[14:12];
    rd = trace_insn[11:7];
    src1 = shadow[trace_insn[19:15]];
    src2 = shadow[trace_insn[24:20]];
    imm_i = {{20{trace_insn[31]}}, trace_insn[31:20]};
    imm_b = {{20{trace_insn[31]}}, trace_insn[7], trace_insn[30:25], trace_insn[11:8], 1'b0};
    imm_j = {{12{trace_insn[31]}}, trace_insn[19:12], trace_insn[20], trace_insn[30:21], 1'b0};
    valid = (trace_status == rv_pipe_pkg::CYCLE_NO_STALL);
    writes_reg = (opcode == rv_isa_pkg::OPC_REG_REG) || (opcode == rv_isa_pkg::OPC_REG_IMM) ||
                 (opcode == rv_isa_pkg::OPC_LUI) || (opcode == rv_isa_pkg::OPC_JAL);
    case (opcode)
      rv_isa_pkg::OPC_LUI: expected = {trace_insn[31:12], 12'h000};
      rv_isa_pkg::OPC_JAL: expected = trace_pc + 32'd4;
      rv_isa_pkg::OPC_REG_IMM: expected = alu(funct3, trace_insn[30] && funct3 == 3'b101,
                                              src1, imm_i);
      default: expected = alu(funct3, trace_insn[30], src1, src2);
    endcase
    case (funct3)
      3'b000: cond_true = (src1 == src2);
      3'b001: cond_true = (src1 != src2);
      3'b100: cond_true = ($signed(src1) < $signed(src2));
      3'b101: cond_true = ($signed(src1) >= $signed(src2));
      3'b110: cond_true = (src1 < src2);
      3'b111: cond_true = (src1 >= src2);
      default: cond_true = 1'b0;
    endcase
    transfer = valid && ((opcode == rv_isa_pkg::OPC_JAL) ||
                         (opcode == rv_isa_pkg::OPC_BRANCH && cond_true));
    jump_target = trace_pc + ((opcode == rv_isa_pkg::OPC_JAL) ? imm_j : imm_b);
    ecall = valid && (trace_insn == 32'h0000_0073);
  end

  // next sequential pc is forgotten across a redirect
  always_ff @(posedge clk) begin
    if (rst) begin
      seq_valid <= 1'b0;
      seq_next_pc <= '0;
    end else if (valid) begin
      seq_valid <= !transfer;
      seq_next_pc <= trace_pc + 32'd4;
    end
  end

  reset_hold: assert property (@(posedge clk)
    rst |=> (trace_status == rv_pipe_pkg::CYCLE_RESET && !trace_reg.we && !halt))
    else begin
      fail_count++;
      $error("writeback left its reset state while reset was applied");
    end

  reset_release: assert property (@(posedge clk)
    $fell(rst) |-> (trace_status == rv_pipe_pkg::CYCLE_RESET) [*3]
                   ##1 (trace_status == rv_pipe_pkg::CYCLE_NO_STALL))
    else begin
      fail_count++;
      $error("first instruction did not reach writeback three cycles after reset");
    end

  bubble_no_write: assert property (@(posedge clk) disable iff (rst)
    !valid |-> !trace_reg.we)
    else begin
      fail_count++;
      $error("register write enabled during a bubble or reset cycle");
    end

  write_data: assert property (@(posedge clk) disable iff (rst)
    (valid && writes_reg && rd != '0) |->
      (trace_reg.we && trace_reg.rd == rd && trace_reg.data == expected))
    else begin
      fail_count++;
      $error("FAILED trace_writeback_reg.data at pc %h: got %h expected %h (we %h rd %h)",
             $sampled(trace_pc), $sampled(trace_reg.data), $sampled(expected),
             $sampled(trace_reg.we), $sampled(trace_reg.rd));
    end

  no_write: assert property (@(posedge clk) disable iff (rst)
    (valid && (!writes_reg || rd == '0)) |-> !trace_reg.we)
    else begin
      fail_count++;
      $error("register write enabled for x0 or a non-writing instruction");
    end

  redirect_flush: assert property (@(posedge clk) disable iff (rst)
    transfer |=> (trace_status == rv_pipe_pkg::CYCLE_TAKEN_BRANCH)
                 ##1 (trace_status == rv_pipe_pkg::CYCLE_TAKEN_BRANCH)
                 ##1 (valid && trace_pc == $past(jump_target, 3)))
    else begin
      fail_count++;
      $error("taken branch or jal not followed by two bubbles and its target");
    end

  sequential_pc: assert property (@(posedge clk) disable iff (rst)
    (valid && seq_valid) |-> (trace_pc == seq_next_pc))
    else begin
      fail_count++;
      $error("FAILED trace_writeback_pc: got %h expected %h",
             $sampled(trace_pc), $sampled(seq_next_pc));
    end

  halt_after_ecall: assert property (@(posedge clk) disable iff (rst) ecall |=> halt)
    else begin
      fail_count++;
      $error("halt did not rise the cycle after ecall");
    end

  halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else begin
      fail_count++;
      $error("halt dropped before reset");
    end

  halt_cause: assert property (@(posedge clk) disable iff (rst) $rose(halt) |-> $past(ecall))
    else begin
      fail_count++;
      $error("halt rose without an ecall in writeback");
    end

endmodule

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_tb;

  localparam int NUM_TESTS = 6;

  logic clk;
  logic rst;
  logic [`RV_XLEN-1:0] imem_pc;
  logic [`RV_INSN_W-1:0] imem_insn;
  logic halt;
  logic [`RV_XLEN-1:0] trace_pc;
  logic [`RV_INSN_W-1:0] trace_insn;
  rv_pipe_pkg::cycle_status_e trace_status;
  rv_pipe_pkg::reg_write_t trace_reg;

  logic [`RV_INSN_W-1:0] imem [0:255];
  int unsigned prog_len;
  int unsigned branch_count;
  logic [`RV_XLEN-1:0] seg_last [NUM_TESTS];
  string seg_name [NUM_TESTS];

  rv_clock_gen clock_i (
    .clk (clk),
    .rst (rst)
  );

  rv_core dut_i (
    .clk                          (clk),
    .rst                          (rst),
    .imem_pc                      (imem_pc),
    .imem_insn                    (imem_insn),
    .halt                         (halt),
    .trace_writeback_pc           (trace_pc),
    .trace_writeback_insn         (trace_insn),
    .trace_writeback_cycle_status (trace_status),
    .trace_writeback_reg          (trace_reg)
  );

  bind rv_core rv_core_assertions checks_i (
    .clk          (clk),
    .rst          (rst),
    .halt         (halt),
    .trace_pc     (trace_writeback_pc),
    .trace_insn   (trace_writeback_insn),
    .trace_status (trace_writeback_cycle_status),
    .trace_reg    (trace_writeback_reg)
  );

  // instruction memory answers in the same cycle
  assign imem_insn = imem[imem_pc[9:2]];

  function automatic logic [31:0] r_insn(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] imm_insn(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_insn(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] branch_insn(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_insn(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic put(input logic [31:0] insn);
    imem[prog_len] = insn;
    if (insn[6:0] == 7'b1100011 || insn[6:0] == 7'b1101111) begin
      branch_count++;
    end
    prog_len++;
  endtask

  task automatic close_segment(input int idx, input string name);
    seg_last[idx] = (prog_len - 1) * 4;
    seg_name[idx] = name;
  endtask

  // a consumer always sits at least two slots after its producer
  task automatic build_program();
    // unused words are addi x0, x0, <word index>
    for (int i = 0; i < 256; i++) begin
      imem[i] = imm_insn(12'(i), 5'd0, 3'b000, 5'd0);
    end
    prog_len = 0;
    branch_count = 0;
    put(imm_insn(12'd0, 5'd0, 3'b000, 5'd0));
    put(imm_insn(12'd0, 5'd0, 3'b000, 5'd0));
    close_segment(0, "reset");
    put(lui_insn(5'd1, 20'($urandom())));
    put(lui_insn(5'd2, 20'($urandom())));
    put(imm_insn(12'($urandom()), 5'd1, 3'b000, 5'd3));
    put(imm_insn(12'($urandom()), 5'd2, 3'b000, 5'd4));
    put(imm_insn(12'($urandom()), 5'd3, 3'b010, 5'd5));
    put(imm_insn(12'($urandom()), 5'd4, 3'b011, 5'd6));
    put(imm_insn(12'($urandom()), 5'd3, 3'b100, 5'd7));
    put(imm_insn(12'($urandom()), 5'd4, 3'b110, 5'd8));
    put(imm_insn(12'($urandom()), 5'd3, 3'b111, 5'd9));
    put(imm_insn({7'b0000000, 5'($urandom())}, 5'd4, 3'b001, 5'd10));
    put(imm_insn({7'b0000000, 5'($urandom())}, 5'd3, 3'b101, 5'd11));
    put(imm_insn({7'b0100000, 5'($urandom())}, 5'd4, 3'b101, 5'd12));
    close_segment(1, "imm_alu");
    put(r_insn(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd13));
    put(r_insn(7'b0100000, 5'd4, 5'd3, 3'b000, 5'd14));
    put(r_insn(7'b0000000, 5'd2, 5'd1, 3'b001, 5'd15));
    put(r_insn(7'b0000000, 5'd4, 5'd3, 3'b010, 5'd16));
    put(r_insn(7'b0000000, 5'd4, 5'd3, 3'b011, 5'd17));
    put(r_insn(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd18));
    put(r_insn(7'b0000000, 5'd4, 5'd1, 3'b101, 5'd19));
    put(r_insn(7'b0100000, 5'd4, 5'd2, 3'b101, 5'd20));
    put(r_insn(7'b0000000, 5'd4, 5'd3, 3'b110, 5'd21));
    put(r_insn(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd22));
    // write to x0, then read from it
    put(r_insn(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd0));
    put(r_insn(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd23));
    close_segment(2, "reg_alu");
    put(branch_insn(3'b000, 5'd1, 5'd1, 13'd8));
    put(imm_insn(12'd1, 5'd0, 3'b000, 5'd24));
    put(branch_insn(3'b001, 5'd1, 5'd1, 13'd8));
    // exactly one of blt and bge is taken
    put(branch_insn(3'b100, 5'd3, 5'd4, 13'd8));
    put(imm_insn(12'd2, 5'd0, 3'b000, 5'd24));
    put(branch_insn(3'b101, 5'd3, 5'd4, 13'd8));
    put(imm_insn(12'd3, 5'd0, 3'b000, 5'd24));
    put(branch_insn(3'b110, 5'd3, 5'd4, 13'd8));
    put(imm_insn(12'd4, 5'd0, 3'b000, 5'd26));
    put(branch_insn(3'b111, 5'd3, 5'd4, 13'd8));
    put(imm_insn(12'd5, 5'd0, 3'b000, 5'd26));
    put(jal_insn(5'd25, 21'd8));
    put(imm_insn(12'd6, 5'd0, 3'b000, 5'd27));
    put(imm_insn(12'd7, 5'd0, 3'b000, 5'd28));
    close_segment(3, "branch");
    put(imm_insn(12'($urandom()), 5'd0, 3'b000, 5'd29));
    put(branch_insn(3'b001, 5'd1, 5'd1, 13'd12));
    put(imm_insn(12'($urandom()), 5'd0, 3'b000, 5'd30));
    put(imm_insn(12'($urandom()), 5'd29, 3'b011, 5'd31));
    put(r_insn(7'b0000000, 5'd30, 5'd29, 3'b100, 5'd26));
    close_segment(4, "sequence");
    put(32'h0000_0073);
    close_segment(5, "halt");
  endtask

  // trace sampled on the falling edge
  task automatic wait_for_retire(input logic [31:0] pc);
    do begin
      @(negedge clk);
    end while (!(trace_status == rv_pipe_pkg::CYCLE_NO_STALL && trace_pc == pc));
  endtask

  initial begin
    int unsigned limit_ns;
    @(negedge rst);
    limit_ns = (prog_len + 3 * branch_count + 40) * 4;
    #(limit_ns);
    $display("timeout: program did not finish within %0d ns after reset", limit_ns);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int unsigned prev_fails;
    int unsigned failures;
    int unsigned passed;
    int unsigned failed;
    void'($urandom(70));
    prev_fails = 0;
    passed = 0;
    failed = 0;
    build_program();
    @(negedge rst);
    for (int k = 0; k < NUM_TESTS; k++) begin
      wait_for_retire(seg_last[k]);
      @(posedge clk);
      #1;
      // give the halt checks a few cycles
      if (k == NUM_TESTS - 1) begin
        repeat (4) @(posedge clk);
        #1;
      end
      failures = dut_i.checks_i.fail_count - prev_fails;
      prev_fails = dut_i.checks_i.fail_count;
      if (failures == 0) begin
        passed++;
        $display("test %s: ok", seg_name[k]);
      end else begin
        failed++;
        $display("test %s: %0d assertion failures", seg_name[k], failures);
      end
    end
    $display("summary: %0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_regfile.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_core.sv
testbench/rv_clock_gen.sv
testbench/rv_core_assertions.sv
testbench/rv_core_tb.sv
